/* verilog/shift_pkg.sv */
/*
 * Shift unit package.
 * Operation and operand size encodings, datapath widths and small helpers
 * shared by the pipelined x86 shift and rotate unit.
 */
`default_nettype none

package shift_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int DATA_W   = 32;           // architectural word
    localparam int FUNNEL_W = 2 * DATA_W;   // two words side by side
    localparam int WINDOW_W = DATA_W + 1;   // result plus carry bit
    localparam int COUNT_W  = $clog2(DATA_W);

    typedef logic [COUNT_W-1:0] count_t;    // masked to 5 bits like x86
    typedef logic [DATA_W-1:0]  data_t;

    // ----------------------------------------
    // encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        SHL,
        SHR,
        SAR,
        ROL,
        ROR,
        SHLD,
        SHRD
    } shift_op_e;

    typedef enum logic [1:0] {
        SIZE_8,
        SIZE_16,
        SIZE_32
    } opsize_e;

    // left family shares the left funnel window
    function automatic logic is_left(shift_op_e op);
        return (op == SHL) || (op == ROL) || (op == SHLD);
    endfunction

    function automatic int unsigned size_bits(opsize_e size);
        case (size)
            SIZE_8:  return 8;
            SIZE_16: return 16;
            default: return 32;
        endcase
    endfunction

endpackage

`default_nettype wire

/* verilog/shift_stage_if.sv */
/*
 * Pipeline stage link.
 * Valid/ready stream between two shift stages, carrying the operation
 * fields alongside a payload whose width depends on the link.
 */
`timescale 1ns/100ps
`default_nettype none

interface shift_stage_if #(
    parameter int PAYLOAD_W = shift_pkg::FUNNEL_W
) ();
    import shift_pkg::*;

    logic                 valid;
    logic                 ready;
    shift_op_e            op;
    opsize_e              size;
    count_t               count;
    data_t                orig_dst;  // untouched destination operand
    logic [PAYLOAD_W-1:0] payload;

    // upstream side
    modport src (
        output valid, op, size, count, orig_dst, payload,
        input  ready
    );

    // downstream side
    modport dst (
        input  valid, op, size, count, orig_dst, payload,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/shift_decode.sv */
/*
 * Shift unit stage 1.
 * Accepts an operation and builds the 64-bit funnel word that the
 * window stage slices, with operands replicated or filled per size.
 */
`timescale 1ns/100ps
`default_nettype none

module shift_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  shift_pkg::shift_op_e in_op,
    input  shift_pkg::opsize_e   in_size,
    input  shift_pkg::data_t     in_dst,
    input  shift_pkg::data_t     in_src,
    input  shift_pkg::count_t    in_count,
    shift_stage_if.src           down
);
    import shift_pkg::*;

    logic                accept;
    data_t               dst_rep;   // dst repeated to fill a word
    data_t               src_rep;
    data_t               dst_zext;
    data_t               dst_sext;
    logic                sign;
    logic [FUNNEL_W-1:0] funnel;

    assign in_ready = ~down.valid | down.ready;
    assign accept   = in_valid & in_ready;

    // ----------------------------------------
    // operand forms per size
    // ----------------------------------------
    always_comb begin
        case (in_size)
            SIZE_8: begin
                dst_rep  = {4{in_dst[7:0]}};
                src_rep  = {4{in_src[7:0]}};    // not used by legal ops
                sign     = in_dst[7];
                dst_zext = {24'b0, in_dst[7:0]};
                dst_sext = {{24{sign}}, in_dst[7:0]};
            end
            SIZE_16: begin
                dst_rep  = {2{in_dst[15:0]}};
                src_rep  = {2{in_src[15:0]}};
                sign     = in_dst[15];
                dst_zext = {16'b0, in_dst[15:0]};
                dst_sext = {{16{sign}}, in_dst[15:0]};
            end
            default: begin
                dst_rep  = in_dst;
                src_rep  = in_src;
                sign     = in_dst[31];
                dst_zext = in_dst;
                dst_sext = in_dst;
            end
        endcase
    end

    always_comb begin
        case (in_op)
            SHL:      funnel = {dst_rep, {DATA_W{1'b0}}};
            SHR:      funnel = {{DATA_W{1'b0}}, dst_zext};
            SAR:      funnel = {{DATA_W{sign}}, dst_sext};
            ROL, ROR: funnel = {dst_rep, dst_rep};
            SHLD:     funnel = {dst_rep, src_rep};      // src fills from below
            default:  funnel = (in_size == SIZE_16) ?   // SHRD, src fills from above
                               {src_rep, in_src[15:0], in_dst[15:0]} :
                               {in_src, in_dst};
        endcase
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n)
            down.valid <= 1'b0;
        else if (accept)
            down.valid <= 1'b1;
        else if (down.ready)
            down.valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            down.op       <= in_op;
            down.size     <= in_size;
            down.count    <= in_count;
            down.orig_dst <= in_dst;
            down.payload  <= funnel;
        end
    end

    // double-precision shifts only exist for 16 and 32-bit operands
    a_shxd_size: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && (in_op == SHLD || in_op == SHRD) |-> in_size != SIZE_8)
        else $error("shift_decode: SHLD/SHRD issued with 8-bit operand size");

endmodule

`default_nettype wire

/* verilog/shift_funnel.sv */
/*
 * Shift unit stage 2.
 * Slides a 33-bit window over the funnel word by the shift count.
 * Left ops keep the carry-out in the top bit, right ops in bit 0.
 */
`timescale 1ns/100ps
`default_nettype none

module shift_funnel (
    input  logic       clk,
    input  logic       rst_n,
    shift_stage_if.dst up,
    shift_stage_if.src down
);
    import shift_pkg::*;

    logic                accept;
    logic [FUNNEL_W:0]   left_ext;   // extra bit above for count zero
    logic [FUNNEL_W:0]   right_ext;  // extra bit below for count zero
    logic [WINDOW_W-1:0] window;

    assign up.ready = ~down.valid | down.ready;
    assign accept   = up.valid & up.ready;

    // ----------------------------------------
    // window select
    // ----------------------------------------
    // left: bits [64-c : 32-c] of the funnel, carry on top
    assign left_ext  = {1'b0, up.payload} << up.count;
    // right: bits [31+c : c-1], last bit shifted out in bit 0
    assign right_ext = {up.payload, 1'b0} >> up.count;

    always_comb begin
        if (is_left(up.op))
            window = left_ext[FUNNEL_W -: WINDOW_W];
        else
            window = right_ext[WINDOW_W-1:0];
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n)
            down.valid <= 1'b0;
        else if (accept)
            down.valid <= 1'b1;
        else if (down.ready)
            down.valid <= 1'b0;   // drained downstream
    end

    // held while stalled, only reloaded on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            down.op       <= up.op;
            down.size     <= up.size;
            down.count    <= up.count;
            down.orig_dst <= up.orig_dst;
            down.payload  <= window;
        end
    end

endmodule

`default_nettype wire

/* verilog/shift_flags.sv */
/*
 * Shift unit stage 3.
 * Cuts the window to the operand size, derives carry and overflow,
 * and registers the result with the write and flag-update strobes.
 */
`timescale 1ns/100ps
`default_nettype none

module shift_flags (
    input  logic              clk,
    input  logic              rst_n,
    shift_stage_if.dst        up,
    output logic              out_valid,
    input  logic              out_ready,
    output shift_pkg::data_t  out_result,
    output logic              out_cflag,
    output logic              out_oflag,
    output logic              out_flags_update,
    output logic              out_no_write
);
    import shift_pkg::*;

    logic  accept;
    data_t full;        // unsized result bits
    data_t result;
    data_t dst_sized;
    logic  top_bit;
    logic  next_bit;
    logic  edge_bit;    // left carry at the operand width
    logic  rot_wrap;    // count is a whole multiple of the width
    logic  cflag;
    logic  oflag;
    logic  no_write;

    assign up.ready = ~out_valid | out_ready;
    assign accept   = up.valid & up.ready;
    assign full     = is_left(up.op) ? up.payload[DATA_W-1:0] : up.payload[DATA_W:1];

    always_comb begin
        case (up.size)
            SIZE_8: begin
                result    = {24'b0, full[7:0]};
                dst_sized = {24'b0, up.orig_dst[7:0]};
                top_bit   = full[7];
                next_bit  = full[6];
                edge_bit  = up.payload[8];
                rot_wrap  = (up.count[2:0] == 3'd0);
            end
            SIZE_16: begin
                result    = {16'b0, full[15:0]};
                dst_sized = {16'b0, up.orig_dst[15:0]};
                top_bit   = full[15];
                next_bit  = full[14];
                edge_bit  = up.payload[16];
                rot_wrap  = (up.count[3:0] == 4'd0);
            end
            default: begin
                result    = full;
                dst_sized = up.orig_dst;
                top_bit   = full[31];
                next_bit  = full[30];
                edge_bit  = up.payload[32];
                rot_wrap  = 1'b0;
            end
        endcase

        // ----------------------------------------
        // carry and overflow
        // ----------------------------------------
        cflag = is_left(up.op) ? edge_bit : up.payload[0];
        if ((up.op == SHL || up.op == SHLD) && up.count > size_bits(up.size))
            cflag = 1'b0;   // everything shifted out

        case (up.op)
            SHL, SHLD:      oflag = top_bit ^ cflag;
            SHR, SHRD, ROR: oflag = top_bit ^ next_bit;
            ROL:            oflag = top_bit ^ result[0];
            default:        oflag = 1'b0;   // SAR
        endcase

        no_write = (up.count == '0) || ((up.op == ROL || up.op == ROR) && rot_wrap);

        if (up.count == '0) begin
            result = dst_sized;   // destination passes through
            cflag  = 1'b0;
            oflag  = 1'b0;
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_result       <= result;
            out_cflag        <= cflag;
            out_oflag        <= oflag;
            out_flags_update <= (up.count != '0);
            out_no_write     <= no_write;
        end
    end

    // a stalled output must not change under the consumer
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result) &&
        $stable(out_cflag) && $stable(out_oflag) &&
        $stable(out_flags_update) && $stable(out_no_write))
        else $error("shift_flags: output changed while stalled");

endmodule

`default_nettype wire

/* verilog/shift_unit_top.sv */
/*
 * Pipelined x86 shift and rotate unit.
 * Three stages, decode, window select and flags, chained by
 * valid/ready links with a latency of three cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module shift_unit_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  shift_pkg::shift_op_e in_op,
    input  shift_pkg::opsize_e   in_size,
    input  shift_pkg::data_t     in_dst,
    input  shift_pkg::data_t     in_src,
    input  shift_pkg::count_t    in_count,
    output logic                 out_valid,
    input  logic                 out_ready,
    output shift_pkg::data_t     out_result,
    output logic                 out_cflag,
    output logic                 out_oflag,
    output logic                 out_flags_update,
    output logic                 out_no_write
);
    import shift_pkg::*;

    // ----------------------------------------
    // stage links
    // ----------------------------------------
    shift_stage_if #(.PAYLOAD_W(FUNNEL_W)) link_a ();   // funnel word
    shift_stage_if #(.PAYLOAD_W(WINDOW_W)) link_b ();   // shifted window

    shift_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .in_size  (in_size),
        .in_dst   (in_dst),
        .in_src   (in_src),
        .in_count (in_count),
        .down     (link_a.src)
    );

    shift_funnel u_funnel (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (link_a.dst),
        .down  (link_b.src)
    );

    shift_flags u_flags (
        .clk              (clk),
        .rst_n            (rst_n),
        .up               (link_b.dst),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_result       (out_result),
        .out_cflag        (out_cflag),
        .out_oflag        (out_oflag),
        .out_flags_update (out_flags_update),
        .out_no_write     (out_no_write)
    );

endmodule

`default_nettype wire

/* include/shift_ref.svh */
/*
 * Shift unit reference model.
 * Computes the expected result, flags and strobes of one operation
 * directly from the x86 rules, independent of the funnel datapath.
 */
`ifndef SHIFT_REF_SVH
`define SHIFT_REF_SVH

typedef struct packed {
    logic [31:0] result;
    logic        cflag;
    logic        oflag;
    logic        flags_update;
    logic        no_write;
} shift_exp_t;

function automatic shift_exp_t shift_ref(
    input shift_pkg::shift_op_e op,
    input shift_pkg::opsize_e   size,
    input shift_pkg::data_t     dst,
    input shift_pkg::data_t     src,
    input shift_pkg::count_t    count
);
    shift_exp_t  exp;
    int unsigned w;
    int unsigned c;
    int unsigned k;
    logic [63:0] mask;
    logic [63:0] d;
    logic [63:0] s;
    logic [63:0] sx;
    logic [63:0] t;

    case (size)
        shift_pkg::SIZE_8:  w = 8;
        shift_pkg::SIZE_16: w = 16;
        default:            w = 32;
    endcase
    c    = count;
    k    = c % w;
    mask = (64'd1 << w) - 64'd1;
    d    = {32'b0, dst} & mask;
    s    = {32'b0, src} & mask;
    sx   = d[w-1] ? (d | ~mask) : d;   // sign extended to 64 bits
    exp  = '0;

    if (c == 0) begin
        exp.result   = d[31:0];
        exp.no_write = 1'b1;
        return exp;
    end

    t = '0;
    case (op)
        shift_pkg::SHL:  begin t = d << c; exp.cflag = (c > w) ? 1'b0 : t[w]; end
        shift_pkg::SHR:  begin t = d >> c; exp.cflag = d[c-1]; end
        shift_pkg::SAR:  begin t = sx >> c; exp.cflag = sx[c-1]; end
        shift_pkg::ROL:  t = (d << k) | (d >> (w - k));
        shift_pkg::ROR:  t = (d >> k) | (d << (w - k));
        shift_pkg::SHLD: begin t = (d << c) | (s >> (w - c)); exp.cflag = t[w]; end
        default:         begin t = (d >> c) | (s << (w - c)); exp.cflag = d[c-1]; end
    endcase
    t = t & mask;

    case (op)
        shift_pkg::SHL, shift_pkg::SHLD: exp.oflag = t[w-1] ^ exp.cflag;
        shift_pkg::SHR, shift_pkg::SHRD: exp.oflag = t[w-1] ^ t[w-2];
        shift_pkg::ROL: begin
            exp.cflag = t[0];
            exp.oflag = t[w-1] ^ t[0];
        end
        shift_pkg::ROR: begin
            exp.cflag = t[w-1];
            exp.oflag = t[w-1] ^ t[w-2];
        end
        default: exp.oflag = 1'b0;
    endcase

    exp.result       = t[31:0];
    exp.flags_update = 1'b1;
    exp.no_write     = (op == shift_pkg::ROL || op == shift_pkg::ROR) && w != 32 && k == 0;
    return exp;
endfunction

`endif

/* verif/tb_shift_unit.sv */
/*
 * Testbench for the pipelined shift and rotate unit.
 * Drives directed and random items through the valid/ready input, checks
 * every output against the reference model, stalls and latency.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_shift_unit;
    import shift_pkg::*;

    `include "shift_ref.svh"

    localparam int WAIT_LIMIT = 200;    // cycles allowed per wait

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    shift_op_e in_op;
    opsize_e   in_size;
    data_t     in_dst;
    data_t     in_src;
    count_t    in_count;
    logic      out_valid;
    logic      out_ready;
    data_t     out_result;
    logic      out_cflag;
    logic      out_oflag;
    logic      out_flags_update;
    logic      out_no_write;

    integer     seed = 32'hf44a_f886;
    int         error_count = 0;
    int         timeout_count = 0;
    int         accept_count = 0;
    int         output_count = 0;
    int         cycle = 0;
    logic       stall_mode = 1'b0;      // random out_ready when set
    logic       check_latency = 1'b1;
    string      test_name = "idle";

    shift_exp_t exp_q[$];               // scoreboard, in issue order
    string      name_q[$];
    int         issue_q[$];             // acceptance cycle per item
    shift_exp_t expected;
    string      item_name;
    int         latency;
    logic       stalled = 1'b0;
    data_t      held_result;
    logic [3:0] held_flags;

    shift_unit_top uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_op            (in_op),
        .in_size          (in_size),
        .in_dst           (in_dst),
        .in_src           (in_src),
        .in_count         (in_count),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_result       (out_result),
        .out_cflag        (out_cflag),
        .out_oflag        (out_oflag),
        .out_flags_update (out_flags_update),
        .out_no_write     (out_no_write)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            error_count++;
            $display("mismatch %s %s: expected %h, actual %h", name, field, exp_val, act_val);
        end
    endtask

    task automatic check_idle(input string phase);
        assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
            error_count++;
            $display("%s: out_valid should be low and in_ready high", phase);
        end
    endtask

    // one clock, then settle at the drive point
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        if (stall_mode) begin
            r = $random(seed);
            out_ready = r[0];
        end
    endtask

    task automatic send_item(input shift_op_e op, input opsize_e size, input data_t dst,
                             input data_t src, input count_t count);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_op    = op;
        in_size  = size;
        in_dst   = dst;
        in_src   = src;
        in_count = count;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        assert (in_ready) else begin
            timeout_count++;
            $display("timeout: in_ready stayed low for %0d cycles in %s", waited, test_name);
        end
        next_cycle();   // acceptance edge
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        logic [31:0] r;
        shift_op_e   op;
        opsize_e     size;
        count_t      count;
        r     = $random(seed);
        op    = shift_op_e'(r[7:0] % 8'd7);
        size  = opsize_e'(r[15:8] % 8'd3);
        count = r[28:24];
        if ((op == SHLD || op == SHRD) && size == SIZE_8)
            size = r[16] ? SIZE_16 : SIZE_32;
        if ((op == SHLD || op == SHRD) && size == SIZE_16 && count > 16)
            count = count - 5'd16;  // 16-bit double shifts stop at 16
        send_item(op, size, $random(seed), $random(seed), count);
    endtask

    task automatic wait_drain();
        int waited;
        waited     = 0;
        stall_mode = 1'b0;
        out_ready  = 1'b1;
        @(negedge clk);
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            timeout_count++;
            $display("timeout: %0d items never left the pipeline in %s",
                     exp_q.size(), test_name);
        end
        next_cycle();
    endtask

    // ----------------------------------------
    // scoreboard and compare
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (stalled) begin
                assert (out_valid && out_result === held_result &&
                        {out_cflag, out_oflag, out_flags_update, out_no_write} === held_flags)
                else begin
                    error_count++;
                    $display("output changed while out_ready was low in %s", test_name);
                end
            end
            if (out_valid && out_ready) begin
                output_count++;
                assert (exp_q.size() != 0) else begin
                    error_count++;
                    $display("output transfer with no item in flight in %s", test_name);
                end
                if (exp_q.size() != 0) begin
                    expected  = exp_q.pop_front();
                    item_name = name_q.pop_front();
                    latency   = cycle - issue_q.pop_front();
                    check_value(item_name, "result", expected.result, out_result);
                    check_value(item_name, "cflag", expected.cflag, out_cflag);
                    check_value(item_name, "oflag", expected.oflag, out_oflag);
                    check_value(item_name, "flags_update", expected.flags_update,
                                out_flags_update);
                    check_value(item_name, "no_write", expected.no_write, out_no_write);
                    if (check_latency)
                        check_value(item_name, "latency", 3, latency);
                end
            end
            if (in_valid && in_ready) begin
                accept_count++;
                exp_q.push_back(shift_ref(in_op, in_size, in_dst, in_src, in_count));
                name_q.push_back($sformatf("%s %s/%s c=%0d", test_name, in_op.name(),
                                           in_size.name(), in_count));
                issue_q.push_back(cycle);
            end
            stalled     = out_valid && !out_ready;
            held_result = out_result;
            held_flags  = {out_cflag, out_oflag, out_flags_update, out_no_write};
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        shift_op_e   basic_ops[3];
        shift_op_e   rot_ops[2];
        shift_op_e   dbl_ops[2];
        opsize_e     sizes[3];
        data_t       patterns[2];
        int          counts[5];
        int unsigned w;

        basic_ops = '{SHL, SHR, SAR};
        rot_ops   = '{ROL, ROR};
        dbl_ops   = '{SHLD, SHRD};
        sizes     = '{SIZE_8, SIZE_16, SIZE_32};
        patterns  = '{32'hc3a5_96f1, 32'h5a0f_7e3c};   // top bit set, then clear

        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_op     = SHL;
        in_size   = SIZE_32;
        in_dst    = '0;
        in_src    = '0;
        in_count  = '0;
        out_ready = 1'b1;

        // reset, then a single item for the latency
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            check_idle("during reset");
        end
        rst_n = 1'b1;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_idle("after reset");
        end
        test_name = "reset_latency";
        send_item(SHL, SIZE_32, 32'h8765_4321, 32'h0, 5'd4);
        wait_drain();

        test_name = "shift_basic";
        foreach (basic_ops[i]) begin
            foreach (sizes[j]) begin
                w      = size_bits(sizes[j]);
                counts = '{0, 1, w - 1, w, 31};     // w=32 wraps to 0
                foreach (patterns[p])
                    foreach (counts[k])
                        send_item(basic_ops[i], sizes[j], patterns[p], 32'h0,
                                  count_t'(counts[k]));
            end
        end
        wait_drain();

        test_name = "rotate";
        foreach (rot_ops[i])
            foreach (sizes[j])
                for (int c = 0; c < 32; c++)
                    send_item(rot_ops[i], sizes[j], $random(seed), 32'h0, count_t'(c));
        wait_drain();

        test_name = "double_shift";
        foreach (dbl_ops[i]) begin
            for (int c = 0; c <= 16; c++)
                send_item(dbl_ops[i], SIZE_16, $random(seed), $random(seed), count_t'(c));
            for (int c = 0; c < 32; c++)
                send_item(dbl_ops[i], SIZE_32, $random(seed), $random(seed), count_t'(c));
        end
        wait_drain();

        test_name = "random_stream";
        repeat (2000)
            send_random();
        wait_drain();

        // random stalls, latency no longer fixed
        test_name     = "back_pressure";
        check_latency = 1'b0;
        stall_mode    = 1'b1;
        repeat (500)
            send_random();
        wait_drain();
        check_latency = 1'b1;

        check_value("item_count", "outputs", accept_count, output_count);

        $display("checked %0d items: %0d errors, %0d timeouts",
                 output_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/shift_pkg.sv
verilog/shift_stage_if.sv
verilog/shift_decode.sv
verilog/shift_funnel.sv
verilog/shift_flags.sv
verilog/shift_unit_top.sv
verif/tb_shift_unit.sv
